// File: verilog/fft_pkg.sv
`default_nettype none

package fft_pkg;

    // Transform size
    localparam int N_POINTS = 32;
    localparam int LOG2_N   = 5;                // Index bits and stage count
    localparam int N_BFLY   = N_POINTS / 2;
    localparam int STAGE_W  = $clog2(LOG2_N);   // Stage 0 to 4

    // Fixed point format
    localparam int DATA_W   = 32;
    localparam int TW_W     = 16;
    localparam int TW_FRAC  = 14;               // Q2.14, 16384 is 1.0
    localparam int BFLY_LAT = 2;

    ////////////////////////////////////////
    // AXI4-Lite address map

    localparam int ADDR_W          = 9;
    localparam int ADDR_REGION_LSB = LOG2_N + 2;    // 32 words per region

    localparam logic [ADDR_W-1:0] ADDR_SAMPLE_BASE    = 9'h000;
    localparam logic [ADDR_W-1:0] ADDR_CTRL           = 9'h080;   // Bit 0 starts
    localparam logic [ADDR_W-1:0] ADDR_STATUS         = 9'h084;   // Bit 0 busy, bit 1 done
    localparam logic [ADDR_W-1:0] ADDR_RESULT_RE_BASE = 9'h100;
    localparam logic [ADDR_W-1:0] ADDR_RESULT_IM_BASE = 9'h180;

endpackage

`default_nettype wire

// File: verilog/fft_bfly_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fft_bfly_if;
    import fft_pkg::*;

    // Operands, one slot per butterfly
    logic signed [DATA_W-1:0] a_re [N_BFLY];
    logic signed [DATA_W-1:0] a_im [N_BFLY];
    logic signed [DATA_W-1:0] b_re [N_BFLY];
    logic signed [DATA_W-1:0] b_im [N_BFLY];
    logic signed [TW_W-1:0]   w_re [N_BFLY];
    logic signed [TW_W-1:0]   w_im [N_BFLY];
    logic                     op_valid;

    // Results
    logic signed [DATA_W-1:0] ya_re [N_BFLY];
    logic signed [DATA_W-1:0] ya_im [N_BFLY];
    logic signed [DATA_W-1:0] yb_re [N_BFLY];
    logic signed [DATA_W-1:0] yb_im [N_BFLY];
    logic                     res_valid;    // From butterfly 0 only

    modport gather (output a_re, a_im, b_re, b_im, op_valid,
                    input  ya_re, ya_im, yb_re, yb_im, res_valid);

    modport twiddle (output w_re, w_im);

    modport unit (input  a_re, a_im, b_re, b_im, w_re, w_im, op_valid,
                  output ya_re, ya_im, yb_re, yb_im, res_valid);

endinterface

`default_nettype wire

// File: verilog/fft_twiddle_rom.sv
`timescale 1ns/1ps
`default_nettype none

module fft_twiddle_rom (
    input  wire                         clk,
    input  wire [fft_pkg::STAGE_W-1:0]  stage_i,
    input  wire                         issue_i,
    fft_bfly_if.twiddle                 tw
);
    import fft_pkg::*;

    // cos(2*pi*k/32) in Q2.14 over a quarter wave
    function automatic logic signed [TW_W-1:0] quarter(input int k);
        case (k)
            0:       return 16'sd16384;
            1:       return 16'sd16069;
            2:       return 16'sd15137;
            3:       return 16'sd13623;
            4:       return 16'sd11585;
            5:       return 16'sd9102;
            6:       return 16'sd6270;
            7:       return 16'sd3196;
            default: return 16'sd0;
        endcase
    endfunction

    function automatic logic signed [TW_W-1:0] tw_cos(input int m);
        return (m <= N_BFLY / 2) ? quarter(m) : -quarter(N_BFLY - m);
    endfunction

    // Minus sine mirrors around m = 8
    function automatic logic signed [TW_W-1:0] tw_nsin(input int m);
        return (m <= N_BFLY / 2) ? -quarter(N_BFLY / 2 - m) : -quarter(m - N_BFLY / 2);
    endfunction

    function automatic int tw_index(input int k, input int s);
        return (k % (1 << s)) << (LOG2_N - 1 - s);
    endfunction

    // Ready with op_valid, one cycle after issue
    always_ff @(posedge clk)
    begin
        if (issue_i)
        begin
            for (int k = 0; k < N_BFLY; k++)
            begin
                tw.w_re[k] <= tw_cos(tw_index(k, int'(stage_i)));
                tw.w_im[k] <= tw_nsin(tw_index(k, int'(stage_i)));
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/fft_butterfly.sv
`timescale 1ns/1ps
`default_nettype none

module fft_butterfly #(
    parameter int IDX = 0
) (
    input  wire         clk,
    input  wire         rst_n_i,
    fft_bfly_if.unit    bfly
);
    import fft_pkg::*;

    logic signed [DATA_W+TW_W:0] prod_re;
    logic signed [DATA_W+TW_W:0] prod_im;
    logic signed [DATA_W-1:0]    a_re_q;
    logic signed [DATA_W-1:0]    a_im_q;
    logic signed [DATA_W-1:0]    p_re_q;
    logic signed [DATA_W-1:0]    p_im_q;
    logic signed [DATA_W-1:0]    ya_re_q;
    logic signed [DATA_W-1:0]    ya_im_q;
    logic signed [DATA_W-1:0]    yb_re_q;
    logic signed [DATA_W-1:0]    yb_im_q;
    logic [BFLY_LAT-1:0]         vld_q;

    // Complex product b * w at full width
    assign prod_re = bfly.b_re[IDX] * bfly.w_re[IDX] - bfly.b_im[IDX] * bfly.w_im[IDX];
    assign prod_im = bfly.b_re[IDX] * bfly.w_im[IDX] + bfly.b_im[IDX] * bfly.w_re[IDX];

    always_ff @(posedge clk)
    begin
        if (bfly.op_valid)
        begin
            a_re_q <= bfly.a_re[IDX];
            a_im_q <= bfly.a_im[IDX];
            p_re_q <= prod_re[TW_FRAC +: DATA_W];   // Arithmetic shift by TW_FRAC
            p_im_q <= prod_im[TW_FRAC +: DATA_W];
        end
        if (vld_q[0])
        begin
            ya_re_q <= a_re_q + p_re_q;
            ya_im_q <= a_im_q + p_im_q;
            yb_re_q <= a_re_q - p_re_q;
            yb_im_q <= a_im_q - p_im_q;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
            vld_q <= '0;
        else
            vld_q <= {vld_q[BFLY_LAT-2:0], bfly.op_valid};
    end

    assign bfly.ya_re[IDX] = ya_re_q;
    assign bfly.ya_im[IDX] = ya_im_q;
    assign bfly.yb_re[IDX] = yb_re_q;
    assign bfly.yb_im[IDX] = yb_im_q;

    generate
        if (IDX == 0)
        begin : g_valid
            assign bfly.res_valid = vld_q[BFLY_LAT-1];

            // Bank valid tracks the gathered operands
            assert property (@(posedge clk) disable iff (!rst_n_i)
                bfly.res_valid == $past(bfly.op_valid, BFLY_LAT));
        end
    endgenerate

endmodule

`default_nettype wire

// File: verilog/fft_work_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fft_work_regs (
    input  wire                                                 clk,
    input  wire                                                 rst_n_i,
    input  wire                                                 load_i,
    input  wire                                                 issue_i,
    input  wire [fft_pkg::STAGE_W-1:0]                          stage_i,
    input  wire [fft_pkg::N_POINTS-1:0][fft_pkg::DATA_W-1:0]    samples_i,
    fft_bfly_if.gather                                          bfly,
    output logic                                                stage_done_o,
    output logic [fft_pkg::N_POINTS-1:0][fft_pkg::DATA_W-1:0]   res_re_o,
    output logic [fft_pkg::N_POINTS-1:0][fft_pkg::DATA_W-1:0]   res_im_o
);
    import fft_pkg::*;

    logic [N_POINTS-1:0][DATA_W-1:0] re_q;
    logic [N_POINTS-1:0][DATA_W-1:0] im_q;

    function automatic logic [LOG2_N-1:0] bit_rev(input logic [LOG2_N-1:0] n);
        logic [LOG2_N-1:0] r;
        for (int i = 0; i < LOG2_N; i++)
            r[i] = n[LOG2_N-1-i];
        return r;
    endfunction

    // Upper element of butterfly k in stage s
    function automatic logic [LOG2_N-1:0] top_idx(input int k, input int s);
        return LOG2_N'(((k >> s) << (s + 1)) + (k % (1 << s)));
    endfunction

    function automatic logic [LOG2_N-1:0] bot_idx(input int k, input int s);
        return top_idx(k, s) + LOG2_N'(1 << s);
    endfunction

    ////////////////////////////////////////
    // Working registers

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            re_q <= '0;
            im_q <= '0;
        end
        else if (load_i)
        begin
            for (int n = 0; n < N_POINTS; n++)
            begin
                re_q[bit_rev(LOG2_N'(n))] <= samples_i[n];
                im_q[n]                   <= '0;   // Real input
            end
        end
        else if (bfly.res_valid)
        begin
            for (int k = 0; k < N_BFLY; k++)
            begin
                re_q[top_idx(k, int'(stage_i))] <= bfly.ya_re[k];
                im_q[top_idx(k, int'(stage_i))] <= bfly.ya_im[k];
                re_q[bot_idx(k, int'(stage_i))] <= bfly.yb_re[k];
                im_q[bot_idx(k, int'(stage_i))] <= bfly.yb_im[k];
            end
        end
    end

    // Pair gathering for the current stage
    always_ff @(posedge clk)
    begin
        if (issue_i)
        begin
            for (int k = 0; k < N_BFLY; k++)
            begin
                bfly.a_re[k] <= re_q[top_idx(k, int'(stage_i))];
                bfly.a_im[k] <= im_q[top_idx(k, int'(stage_i))];
                bfly.b_re[k] <= re_q[bot_idx(k, int'(stage_i))];
                bfly.b_im[k] <= im_q[bot_idx(k, int'(stage_i))];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            bfly.op_valid <= 1'b0;
            stage_done_o  <= 1'b0;
        end
        else
        begin
            bfly.op_valid <= issue_i;
            stage_done_o  <= bfly.res_valid;   // Write-back landed
        end
    end

    assign res_re_o = re_q;
    assign res_im_o = im_q;

endmodule

`default_nettype wire

// File: verilog/fft_stage_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fft_stage_ctrl (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         start_i,
    input  wire                         stage_done_i,
    output logic                        load_o,
    output logic                        issue_o,
    output logic                        busy_o,
    output logic                        done_o,
    output logic [fft_pkg::STAGE_W-1:0] stage_o
);
    import fft_pkg::*;

    enum logic [2:0] {s_idle, s_load, s_issue, s_wait, s_done} state_q, state_d;

    logic last_stage;

    assign last_stage = (stage_o == STAGE_W'(LOG2_N - 1));

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            state_q <= s_idle;
            stage_o <= '0;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == s_load)
                stage_o <= '0;
            else if (state_q == s_wait && stage_done_i && !last_stage)
                stage_o <= stage_o + 1'b1;
        end
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            s_idle, s_done:
                if (start_i)
                    state_d = s_load;   // done holds until here
            s_load:
                state_d = s_issue;
            s_issue:
                state_d = s_wait;
            s_wait:
                if (stage_done_i)
                    state_d = last_stage ? s_done : s_issue;
            default:
                state_d = s_idle;
        endcase
    end

    assign load_o  = (state_q == s_load);
    assign issue_o = (state_q == s_issue);
    assign busy_o  = (state_q == s_load) || (state_q == s_issue) || (state_q == s_wait);
    assign done_o  = (state_q == s_done);

    ////////////////////////////////////////
    // Checks

    assert property (@(posedge clk) disable iff (!rst_n_i)
        busy_o |-> stage_o < STAGE_W'(LOG2_N));

    // Fixed round trip through gather, butterflies and write-back
    assert property (@(posedge clk) disable iff (!rst_n_i)
        stage_done_i |-> $past(issue_o, BFLY_LAT + 2));

endmodule

`default_nettype wire

// File: verilog/fft_axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fft_axil_regs (
    input  wire                                                 clk,
    input  wire                                                 rst_n_i,
    input  wire [fft_pkg::ADDR_W-1:0]                           awaddr_i,
    input  wire                                                 awvalid_i,
    output logic                                                awready_o,
    input  wire [fft_pkg::DATA_W-1:0]                           wdata_i,
    input  wire [fft_pkg::DATA_W/8-1:0]                         wstrb_i,
    input  wire                                                 wvalid_i,
    output logic                                                wready_o,
    output logic [1:0]                                          bresp_o,
    output logic                                                bvalid_o,
    input  wire                                                 bready_i,
    input  wire [fft_pkg::ADDR_W-1:0]                           araddr_i,
    input  wire                                                 arvalid_i,
    output logic                                                arready_o,
    output logic [fft_pkg::DATA_W-1:0]                          rdata_o,
    output logic [1:0]                                          rresp_o,
    output logic                                                rvalid_o,
    input  wire                                                 rready_i,
    input  wire                                                 busy_i,
    input  wire                                                 done_i,
    output logic                                                start_o,
    output logic [fft_pkg::N_POINTS-1:0][fft_pkg::DATA_W-1:0]   samples_o,
    input  wire [fft_pkg::N_POINTS-1:0][fft_pkg::DATA_W-1:0]    res_re_i,
    input  wire [fft_pkg::N_POINTS-1:0][fft_pkg::DATA_W-1:0]    res_im_i
);
    import fft_pkg::*;

    logic              wr_hs;
    logic              rd_hs;
    logic              wr_sample;
    logic [LOG2_N-1:0] wr_idx;
    logic [LOG2_N-1:0] rd_idx;
    logic [DATA_W-1:0] rd_data;

    assign wr_hs  = awready_o && awvalid_i && wvalid_i;
    assign rd_hs  = arready_o && arvalid_i;
    assign wr_idx = awaddr_i[ADDR_REGION_LSB-1:2];
    assign rd_idx = araddr_i[ADDR_REGION_LSB-1:2];

    // Samples are frozen from the start pulse on
    assign wr_sample = wr_hs && !busy_i && !start_o &&
        awaddr_i[ADDR_W-1:ADDR_REGION_LSB] == ADDR_SAMPLE_BASE[ADDR_W-1:ADDR_REGION_LSB];

    ////////////////////////////////////////
    // Write channel

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            awready_o <= 1'b0;
            bvalid_o  <= 1'b0;
            start_o   <= 1'b0;
        end
        else
        begin
            awready_o <= awvalid_i && wvalid_i && !awready_o && !bvalid_o;
            if (wr_hs)
                bvalid_o <= 1'b1;
            else if (bready_i)
                bvalid_o <= 1'b0;
            start_o <= wr_hs && awaddr_i == ADDR_CTRL && wstrb_i[0] && wdata_i[0] && !busy_i;
        end
    end

    assign wready_o = awready_o;    // Address and data taken together
    assign bresp_o  = 2'b00;        // OKAY

    always_ff @(posedge clk)
    begin
        if (wr_sample)
        begin
            for (int b = 0; b < DATA_W / 8; b++)
            begin
                if (wstrb_i[b])
                    samples_o[wr_idx][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
    end

    ////////////////////////////////////////
    // Read channel

    always_comb
    begin
        rd_data = '0;
        case (araddr_i[ADDR_W-1:ADDR_REGION_LSB])
            ADDR_RESULT_RE_BASE[ADDR_W-1:ADDR_REGION_LSB]:
                rd_data = res_re_i[rd_idx];
            ADDR_RESULT_IM_BASE[ADDR_W-1:ADDR_REGION_LSB]:
                rd_data = res_im_i[rd_idx];
            ADDR_STATUS[ADDR_W-1:ADDR_REGION_LSB]:
                if (araddr_i == ADDR_STATUS)
                    rd_data[1:0] = {done_i, busy_i};
            default:
                rd_data = '0;   // Unmapped and write-only words
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
        end
        else
        begin
            arready_o <= arvalid_i && !arready_o && !rvalid_o;
            if (rd_hs)
                rvalid_o <= 1'b1;
            else if (rready_i)
                rvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_hs)
            rdata_o <= rd_data;
    end

    assign rresp_o = 2'b00;

    assert property (@(posedge clk) disable iff (!rst_n_i)
        bvalid_o && !bready_i |=> bvalid_o);

    assert property (@(posedge clk) disable iff (!rst_n_i)
        rvalid_o && !rready_i |=> rvalid_o);

endmodule

`default_nettype wire

// File: verilog/fft_seq_top.sv
`timescale 1ns/1ps
`default_nettype none

module fft_seq_top (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire [fft_pkg::ADDR_W-1:0]    awaddr_i,
    input  wire                          awvalid_i,
    output logic                         awready_o,
    input  wire [fft_pkg::DATA_W-1:0]    wdata_i,
    input  wire [fft_pkg::DATA_W/8-1:0]  wstrb_i,
    input  wire                          wvalid_i,
    output logic                         wready_o,
    output logic [1:0]                   bresp_o,
    output logic                         bvalid_o,
    input  wire                          bready_i,
    input  wire [fft_pkg::ADDR_W-1:0]    araddr_i,
    input  wire                          arvalid_i,
    output logic                         arready_o,
    output logic [fft_pkg::DATA_W-1:0]   rdata_o,
    output logic [1:0]                   rresp_o,
    output logic                         rvalid_o,
    input  wire                          rready_i
);
    import fft_pkg::*;

    logic                            start;
    logic                            load;
    logic                            issue;
    logic                            busy;
    logic                            done;
    logic                            stage_done;
    logic [STAGE_W-1:0]              stage;
    logic [N_POINTS-1:0][DATA_W-1:0] samples;
    logic [N_POINTS-1:0][DATA_W-1:0] res_re;
    logic [N_POINTS-1:0][DATA_W-1:0] res_im;

    fft_bfly_if bfly ();

    fft_axil_regs u_axil (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .awaddr_i  (awaddr_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .wdata_i   (wdata_i),
        .wstrb_i   (wstrb_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bresp_o   (bresp_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .araddr_i  (araddr_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .busy_i    (busy),
        .done_i    (done),
        .start_o   (start),
        .samples_o (samples),
        .res_re_i  (res_re),
        .res_im_i  (res_im)
    );

    fft_stage_ctrl u_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .start_i      (start),
        .stage_done_i (stage_done),
        .load_o       (load),
        .issue_o      (issue),
        .busy_o       (busy),
        .done_o       (done),
        .stage_o      (stage)
    );

    fft_work_regs u_work (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .load_i       (load),
        .issue_i      (issue),
        .stage_i      (stage),
        .samples_i    (samples),
        .bfly         (bfly),
        .stage_done_o (stage_done),
        .res_re_o     (res_re),
        .res_im_o     (res_im)
    );

    fft_twiddle_rom u_twiddle (
        .clk     (clk),
        .stage_i (stage),
        .issue_i (issue),
        .tw      (bfly)
    );

    // Butterfly bank, reused by every stage
    genvar k;
    generate
        for (k = 0; k < N_BFLY; k++)
        begin : g_bfly
            fft_butterfly #(
                .IDX (k)
            ) u_bfly (
                .clk     (clk),
                .rst_n_i (rst_n_i),
                .bfly    (bfly)
            );
        end
    endgenerate

endmodule

`default_nettype wire

// File: include/fft_tb_axil.svh
`ifndef FFT_TB_AXIL_SVH
`define FFT_TB_AXIL_SVH

// One AXI4-Lite write with bready held low for hold cycles once bvalid is up
task write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
               input int hold);
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = (hold == 0);
    @(posedge clk);
    #1;
    while (!(awready && wready))
    begin
        @(posedge clk);
        #1;
    end
    @(posedge clk);     // Handshake edge
    #1;
    check_word("bvalid", int'(addr), int'(bvalid), 1, 0);
    check_word("bresp", int'(addr), int'(bresp), 0, 0);
    // Address and data stay offered while the response waits
    for (int i = 0; i < hold; i++)
    begin
        check_word("bvalid held", i, int'(bvalid), 1, 0);
        check_word("awready while bvalid", i, int'(awready), 0, 0);
        @(posedge clk);
        #1;
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    @(posedge clk);
    #1;
endtask

// One AXI4-Lite read with rready held high
task read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    araddr  = addr;
    arvalid = 1'b1;
    @(posedge clk);
    #1;
    while (!arready)
    begin
        @(posedge clk);
        #1;
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    check_word("rvalid", int'(addr), int'(rvalid), 1, 0);
    check_word("rresp", int'(addr), int'(rresp), 0, 0);
    data = rdata;
    @(posedge clk);
    #1;
endtask

function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

`endif

// File: testbench/fft_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fft_tb;
    import fft_pkg::*;

    localparam real PI          = 3.14159265358979;
    localparam real TW_ONE      = 16384.0;      // Q2.14 unit
    localparam int  N_TESTS     = 6;
    localparam int  MAX_ACCESS  = 300;          // AXI accesses of the longest test
    localparam int  WATCHDOG_NS = N_TESTS * (MAX_ACCESS * 10 + 100) * 10;
    localparam logic [ADDR_W-1:0] ADDR_UNMAPPED = 9'h0C0;

    logic                clk;
    logic                rst_n_i;
    logic [ADDR_W-1:0]   awaddr;
    logic                awvalid;
    logic                awready;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W/8-1:0] wstrb;
    logic                wvalid;
    logic                wready;
    logic [1:0]          bresp;
    logic                bvalid;
    logic                bready;
    logic [ADDR_W-1:0]   araddr;
    logic                arvalid;
    logic                arready;
    logic [DATA_W-1:0]   rdata;
    logic [1:0]          rresp;
    logic                rvalid;
    logic                rready;

    int                errors;
    int                checks;
    int                err_mark;
    int                chk_mark;
    int unsigned       lcg_state;
    int                x      [N_POINTS];
    int                got_re [N_POINTS];
    int                got_im [N_POINTS];
    real               ref_re [N_POINTS];
    real               ref_im [N_POINTS];
    real               tw_re  [N_POINTS];
    real               tw_im  [N_POINTS];
    logic [DATA_W-1:0] word;

    `include "fft_tb_axil.svh"

    fft_seq_top UUT (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .awaddr_i  (awaddr),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .wdata_i   (wdata),
        .wstrb_i   (wstrb),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .bresp_o   (bresp),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .araddr_i  (araddr),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .rdata_o   (rdata),
        .rresp_o   (rresp),
        .rvalid_o  (rvalid),
        .rready_i  (rready)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Run timed out after %0d ns, the DUT stopped answering", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

    task check_word(input string what, input int idx, input int got, input int exp,
                    input int tol);
        checks++;
        assert (got >= exp - tol && got <= exp + tol)
        else
        begin
            $display("error at %0t: %s[%0d] read %0d, expected %0d within %0d",
                     $time, what, idx, got, exp, tol);
            errors++;
        end
    endtask

    task start_test();
        err_mark = errors;
        chk_mark = checks;
    endtask

    task finish_test(input string name);
        $display("Test %s: %0d checks, %0d errors", name, checks - chk_mark, errors - err_mark);
    endtask

    ////////////////////////////////////////
    // Reference DFT

    // Rounded Q2.14 twiddles of cos and minus sin
    function automatic void build_twiddles();
        real ang;
        for (int m = 0; m < N_POINTS; m++)
        begin
            ang      = 2.0 * PI * m / N_POINTS;
            tw_re[m] = real'(int'($cos(ang) * TW_ONE)) / TW_ONE;
            tw_im[m] = real'(int'(-$sin(ang) * TW_ONE)) / TW_ONE;
        end
    endfunction

    function automatic void compute_reference();
        int m;
        for (int k = 0; k < N_POINTS; k++)
        begin
            ref_re[k] = 0.0;
            ref_im[k] = 0.0;
            for (int n = 0; n < N_POINTS; n++)
            begin
                m = (n * k) % N_POINTS;
                ref_re[k] += real'(x[n]) * tw_re[m];
                ref_im[k] += real'(x[n]) * tw_im[m];
            end
        end
    endfunction

    function automatic int tolerance();
        int sum_abs;
        sum_abs = 0;
        for (int n = 0; n < N_POINTS; n++)
            sum_abs += (x[n] < 0) ? -x[n] : x[n];
        return 4 * sum_abs / 16384 + 8;
    endfunction

    task check_against_reference();
        int tol;
        tol = tolerance();
        compute_reference();
        for (int k = 0; k < N_POINTS; k++)
        begin
            check_word("re", k, got_re[k], int'(ref_re[k]), tol);
            check_word("im", k, got_im[k], int'(ref_im[k]), tol);
        end
    endtask

    ////////////////////////////////////////
    // Transform steps

    task load_samples();
        for (int n = 0; n < N_POINTS; n++)
            write_reg(ADDR_SAMPLE_BASE + ADDR_W'(4 * n), x[n], 0);
    endtask

    task fill_random();
        for (int n = 0; n < N_POINTS; n++)
            x[n] = int'(next_random() >> 16) - 32768;   // -2^15 to 2^15-1
    endtask

    task wait_done();
        logic [DATA_W-1:0] status;
        do
            read_reg(ADDR_STATUS, status);
        while (!status[1]);
    endtask

    task read_results();
        logic [DATA_W-1:0] data;
        for (int k = 0; k < N_POINTS; k++)
        begin
            read_reg(ADDR_RESULT_RE_BASE + ADDR_W'(4 * k), data);
            got_re[k] = data;
            read_reg(ADDR_RESULT_IM_BASE + ADDR_W'(4 * k), data);
            got_im[k] = data;
        end
    endtask

    task run_transform();
        load_samples();
        write_reg(ADDR_CTRL, 32'd1, 0);
        wait_done();
        read_results();
    endtask

    initial
    begin
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b1;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b1;
        rst_n_i   = 1'b0;
        errors    = 0;
        checks    = 0;
        lcg_state = 32'd58949;
        build_twiddles();
        repeat (4) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        start_test();
        read_reg(ADDR_STATUS, word);
        check_word("status", 0, int'(word), 0, 0);
        read_results();
        for (int k = 0; k < N_POINTS; k++)
        begin
            check_word("re", k, got_re[k], 0, 0);
            check_word("im", k, got_im[k], 0, 0);
        end
        read_reg(ADDR_UNMAPPED, word);
        check_word("unmapped", int'(ADDR_UNMAPPED), int'(word), 0, 0);
        finish_test("reset state");

        start_test();
        for (int n = 0; n < N_POINTS; n++)
            x[n] = (n == 0) ? 1000 : 0;
        run_transform();
        for (int k = 0; k < N_POINTS; k++)
        begin
            check_word("re", k, got_re[k], 1000, 0);    // Flat spectrum
            check_word("im", k, got_im[k], 0, 0);
        end
        finish_test("impulse");

        start_test();
        for (int n = 0; n < N_POINTS; n++)
            x[n] = 500;
        run_transform();
        check_word("dc re", 0, got_re[0], 16000, 0);
        check_word("dc im", 0, got_im[0], 0, 0);
        check_against_reference();
        finish_test("constant");

        start_test();
        for (int n = 0; n < N_POINTS; n++)
            x[n] = int'(4000.0 * $cos(2.0 * PI * n / N_POINTS));
        run_transform();
        check_word("peak re", 1, got_re[1], 64000, tolerance());
        check_word("peak re", 31, got_re[31], 64000, tolerance());
        check_against_reference();
        finish_test("single tone");

        start_test();
        repeat (2)
        begin
            fill_random();
            run_transform();
            check_against_reference();
        end
        finish_test("random inputs");

        ////////////////////////////////////////
        // Sample writes during a running transform

        start_test();
        fill_random();
        load_samples();
        write_reg(ADDR_CTRL, 32'd1, 0);
        read_reg(ADDR_STATUS, word);
        check_word("busy after start", 0, int'(word[0]), 1, 0);
        write_reg(ADDR_SAMPLE_BASE, 32'd12345, 4);
        write_reg(ADDR_SAMPLE_BASE + ADDR_W'(4), 32'hFFFF0000, 4);
        wait_done();
        read_results();
        check_against_reference();  // Still the samples from before start
        write_reg(ADDR_CTRL, 32'd1, 0);
        wait_done();
        read_results();
        check_against_reference();  // Buffer kept through the busy writes
        fill_random();
        run_transform();
        check_against_reference();
        finish_test("writes while busy");

        $display("%0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
verilog/fft_pkg.sv
verilog/fft_bfly_if.sv
verilog/fft_twiddle_rom.sv
verilog/fft_butterfly.sv
verilog/fft_work_regs.sv
verilog/fft_stage_ctrl.sv
verilog/fft_axil_regs.sv
verilog/fft_seq_top.sv
testbench/fft_tb.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --top-module fft_tb -f src.f -o fft_sim > build.log 2>&1 \
    && ./obj_dir/fft_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && exit 1 || exit 0
